// File: hdl/decode_settings.svh
// RV32 integer subset only; changing XLEN alone does not widen the immediate logic
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Data path width
`define XLEN 32

// Register file address width, 32 architectural registers
`define REG_ADDR_W 5

// ALU, branch, load/store, multiply, divide
`define NUM_UNITS 5

// Major opcode field, instruction bits 6:2
`define OPCODE_W 5

`endif

// File: hdl/decode_pkg.sv
// Shared decode types; assumes RV32 encodings and the five execution units listed below
`include "decode_settings.svh"

package decode_pkg;

    //////////////////////////////////////////////////////////////////////
    // Enumerations

    // Major opcodes, instruction bits 6:2
    typedef enum logic [`OPCODE_W-1:0] {
        LOAD      = 5'b00000,
        STORE     = 5'b01000,
        BRANCH    = 5'b11000,
        JAL       = 5'b11011,
        JALR      = 5'b11001,
        LUI       = 5'b01101,
        AUIPC     = 5'b00101,
        ARITH     = 5'b01100,
        ARITH_IMM = 5'b00100,
        OTHER     = 5'b11111
    } opcode_t;

    // Bit positions in unit_vec_t
    typedef enum logic [$clog2(`NUM_UNITS)-1:0] {
        ALU_UNIT = 0,
        BRANCH_UNIT,
        LS_UNIT,
        MUL_UNIT,
        DIV_UNIT
    } unit_id_t;

    typedef enum logic [1:0] {
        ALU_RS1_ZERO,
        ALU_RS1_PC,
        ALU_RS1_RF
    } alu_rs1_sel_t;

    typedef enum logic [1:0] {
        ALU_RS2_UPPER,
        ALU_RS2_IMM,
        ALU_RS2_FOUR,
        ALU_RS2_RF
    } alu_rs2_sel_t;

    //////////////////////////////////////////////////////////////////////
    // Bundles

    typedef logic [`NUM_UNITS-1:0] unit_vec_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instruction;
    } fetch_packet_t;

    typedef struct packed {
        opcode_t opcode;
        logic [2:0] fn3;
        logic [`REG_ADDR_W-1:0] rs1_addr;
        logic [`REG_ADDR_W-1:0] rs2_addr;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic uses_rs1;
        logic uses_rs2;
        logic uses_rd;
        logic is_store;
        unit_vec_t needed;
    } decoded_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1_addr;
        logic [`REG_ADDR_W-1:0] rs2_addr;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic rd_write;
    } regfile_issue_t;

    typedef struct packed {
        logic [`XLEN:0] in1;
        logic [`XLEN:0] in2;
        logic [`XLEN-1:0] shifter_in;
        logic [$clog2(`XLEN)-1:0] shift_amount;
        logic subtract;
        logic arith;
        logic lshift;
        logic [1:0] logic_op;
        logic shifter_path;
        logic slt_path;
    } alu_inputs_t;

    typedef struct packed {
        logic [`XLEN-1:0] rs1;
        logic [`XLEN-1:0] rs2;
        logic [11:0] offset;
        logic [2:0] fn3;
        logic load;
        logic store;
        logic forwarded_store;
    } ls_inputs_t;

    typedef struct packed {
        logic [`XLEN-1:0] rs1;
        logic [`XLEN-1:0] rs2;
        logic [2:0] fn3;
        logic [`XLEN-1:0] pc;
        logic use_signed;
        logic jal;
        logic jalr;
    } branch_inputs_t;

    // Shared by multiply and divide units
    typedef struct packed {
        logic [`XLEN-1:0] rs1;
        logic [`XLEN-1:0] rs2;
        logic [1:0] op;
        logic reuse_result;
    } muldiv_inputs_t;

endpackage

// File: hdl/unit_select.sv
// Unknown opcodes map to OTHER and need no unit, so they never issue; no illegal-instruction check
module unit_select (
    input  decode_pkg::fetch_packet_t fb,
    output decode_pkg::decoded_t decoded
);
    import decode_pkg::*;

    opcode_t opcode;
    logic mult_div_op;

    assign mult_div_op = fb.instruction[25];

    // Map the raw opcode field onto the known set
    always_comb begin
        case (fb.instruction[6:2])
            LOAD, STORE, BRANCH, JAL, JALR, LUI, AUIPC, ARITH, ARITH_IMM:
                opcode = opcode_t'(fb.instruction[6:2]);
            default:
                opcode = OTHER;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Fields and register usage

    assign decoded.opcode   = opcode;
    assign decoded.fn3      = fb.instruction[14:12];
    assign decoded.rs1_addr = fb.instruction[19:15];
    assign decoded.rs2_addr = fb.instruction[24:20];
    assign decoded.rd_addr  = fb.instruction[11:7];

    assign decoded.uses_rs1 = opcode inside {LOAD, STORE, BRANCH, JALR, ARITH, ARITH_IMM};
    assign decoded.uses_rs2 = opcode inside {STORE, BRANCH, ARITH};
    assign decoded.uses_rd  = opcode inside {LOAD, JAL, JALR, LUI, AUIPC, ARITH, ARITH_IMM};
    assign decoded.is_store = (opcode == STORE);

    //////////////////////////////////////////////////////////////////////
    // Needed units

    always_comb begin
        decoded.needed = '0;
        decoded.needed[ALU_UNIT] = (opcode inside {LUI, AUIPC, JAL, JALR, ARITH_IMM}) ||
                                   ((opcode == ARITH) && !mult_div_op);
        // Jumps go to both ALU (link value) and branch unit
        decoded.needed[BRANCH_UNIT] = opcode inside {BRANCH, JAL, JALR};
        decoded.needed[LS_UNIT]     = opcode inside {LOAD, STORE};
        decoded.needed[MUL_UNIT]    = (opcode == ARITH) && mult_div_op && !fb.instruction[14];
        decoded.needed[DIV_UNIT]    = (opcode == ARITH) && mult_div_op && fb.instruction[14];
    end

endmodule

// File: hdl/issue_control.sv
// Issue needs every needed unit ready; stores ignore an rs2 conflict, which the LS unit forwards
`include "decode_settings.svh"

module issue_control (
    input  logic clk,
    input  logic rst,
    input  logic fb_valid,
    input  decode_pkg::decoded_t decoded,
    input  decode_pkg::unit_vec_t unit_ready,
    input  logic rs1_conflict,
    input  logic rs2_conflict,
    input  logic issue_hold,
    input  logic flush,
    output logic instruction_issued,
    output logic pre_decode_pop,
    output decode_pkg::unit_vec_t unit_request,
    output decode_pkg::unit_vec_t unit_request_r,
    output decode_pkg::regfile_issue_t rf_issue
);
    import decode_pkg::*;

    logic issue_valid;
    logic units_ready;
    logic rs1_ok;
    logic rs2_ok;

    //////////////////////////////////////////////////////////////////////
    // Issue decision

    assign issue_valid = fb_valid && !issue_hold && !flush;

    // Nothing needed means nothing to do, so hold it back
    assign units_ready = (|decoded.needed) &&
                         ((decoded.needed & unit_ready) == decoded.needed);

    assign rs1_ok = !rs1_conflict || !decoded.uses_rs1;
    assign rs2_ok = !rs2_conflict || !decoded.uses_rs2 || decoded.is_store;

    assign instruction_issued = issue_valid && units_ready && rs1_ok && rs2_ok;
    assign pre_decode_pop     = instruction_issued;

    assign unit_request = decoded.needed & {`NUM_UNITS{instruction_issued}};

    always_ff @(posedge clk) begin
        if (rst) begin
            unit_request_r <= '0;
        end else begin
            unit_request_r <= unit_request;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Register file bundle

    assign rf_issue.rs1_addr = decoded.rs1_addr;
    assign rf_issue.rs2_addr = decoded.rs2_addr;
    assign rf_issue.rd_addr  = decoded.rd_addr;
    // x0 is never written
    assign rf_issue.rd_write = instruction_issued && decoded.uses_rd && (|decoded.rd_addr);

endmodule

// File: hdl/alu_operand_gen.sv
// RV32 immediates only; the extra operand bit is a sign copy unless fn3 bit 0 marks unsigned
`include "decode_settings.svh"

module alu_operand_gen (
    input  decode_pkg::fetch_packet_t fb,
    input  decode_pkg::decoded_t decoded,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    output decode_pkg::alu_inputs_t alu_inputs
);
    import decode_pkg::*;

    alu_rs1_sel_t rs1_sel;
    alu_rs2_sel_t rs2_sel;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic not_reg_op;
    logic [2:0] fn3;

    assign fn3 = decoded.fn3;
    // Opcode bit 2 is set for LUI, AUIPC, JAL and JALR
    assign not_reg_op = fb.instruction[2];

    //////////////////////////////////////////////////////////////////////
    // Operand selection

    always_comb begin
        case (decoded.opcode)
            LUI:             rs1_sel = ALU_RS1_ZERO;
            AUIPC, JAL, JALR: rs1_sel = ALU_RS1_PC;
            default:         rs1_sel = ALU_RS1_RF;
        endcase
        case (decoded.opcode)
            LUI, AUIPC: rs2_sel = ALU_RS2_UPPER;
            ARITH_IMM:  rs2_sel = ALU_RS2_IMM;
            JAL, JALR:  rs2_sel = ALU_RS2_FOUR;
            default:    rs2_sel = ALU_RS2_RF;
        endcase
    end

    always_comb begin
        case (rs1_sel)
            ALU_RS1_ZERO: op1 = '0;
            ALU_RS1_PC:   op1 = fb.pc;
            default:      op1 = rs1_data;
        endcase
        case (rs2_sel)
            ALU_RS2_UPPER: op2 = {fb.instruction[31:12], 12'b0};
            ALU_RS2_IMM:   op2 = {{(`XLEN-12){fb.instruction[31]}}, fb.instruction[31:20]};
            ALU_RS2_FOUR:  op2 = `XLEN'(4);
            default:       op2 = rs2_data;
        endcase
    end

    assign alu_inputs.in1 = {op1[`XLEN-1] & !fn3[0], op1};
    assign alu_inputs.in2 = {op2[`XLEN-1] & !fn3[0], op2};

    //////////////////////////////////////////////////////////////////////
    // Shifter and path controls

    assign alu_inputs.shifter_in = rs1_data;
    // Register shifts take the amount from rs2, immediate shifts from the rs2 field
    assign alu_inputs.shift_amount = fb.instruction[5] ? rs2_data[$clog2(`XLEN)-1:0]
                                                       : decoded.rs2_addr;
    assign alu_inputs.arith  = op1[`XLEN-1] && fb.instruction[30];
    assign alu_inputs.lshift = !fn3[2];

    // SUB, and the compare for SLT/SLTU
    assign alu_inputs.subtract = ((decoded.opcode == ARITH) && fb.instruction[30] && (fn3 == 3'b000)) ||
                                 (!not_reg_op && (fn3 inside {3'b010, 3'b011}));

    // 00 xor, 01 or, 10 and, 11 add
    always_comb begin
        case (fn3)
            3'b100:  alu_inputs.logic_op = not_reg_op ? 2'b11 : 2'b00;
            3'b110:  alu_inputs.logic_op = not_reg_op ? 2'b11 : 2'b01;
            3'b111:  alu_inputs.logic_op = not_reg_op ? 2'b11 : 2'b10;
            default: alu_inputs.logic_op = 2'b11;
        endcase
    end

    assign alu_inputs.shifter_path = !not_reg_op && (fn3 inside {3'b001, 3'b101});
    assign alu_inputs.slt_path     = !not_reg_op && (fn3 inside {3'b010, 3'b011});

endmodule

// File: hdl/mem_branch_operand_gen.sv
// Load/store, branch and mul/div bundles; reuse_result stays zero here and is merged above
`include "decode_settings.svh"

module mem_branch_operand_gen (
    input  decode_pkg::fetch_packet_t fb,
    input  decode_pkg::decoded_t decoded,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic rs2_conflict,
    output decode_pkg::ls_inputs_t ls_inputs,
    output decode_pkg::branch_inputs_t branch_inputs,
    output decode_pkg::muldiv_inputs_t muldiv_operands
);
    import decode_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Load/store

    assign ls_inputs.rs1 = rs1_data;
    assign ls_inputs.rs2 = rs2_data;
    // S-type splits the offset around the rd field
    assign ls_inputs.offset = decoded.is_store ? {fb.instruction[31:25], fb.instruction[11:7]}
                                               : fb.instruction[31:20];
    assign ls_inputs.fn3   = decoded.fn3;
    assign ls_inputs.load  = (decoded.opcode == LOAD);
    assign ls_inputs.store = decoded.is_store;
    // Store data still in flight, LS unit picks it up later
    assign ls_inputs.forwarded_store = rs2_conflict;

    //////////////////////////////////////////////////////////////////////
    // Branch

    assign branch_inputs.rs1 = rs1_data;
    assign branch_inputs.rs2 = rs2_data;
    assign branch_inputs.fn3 = decoded.fn3;
    assign branch_inputs.pc  = fb.pc;
    // BLTU and BGEU compare unsigned
    assign branch_inputs.use_signed = !(decoded.fn3 inside {3'b110, 3'b111});
    assign branch_inputs.jal  = (decoded.opcode == JAL);
    assign branch_inputs.jalr = (decoded.opcode == JALR);

    //////////////////////////////////////////////////////////////////////
    // Multiply/divide

    assign muldiv_operands.rs1 = rs1_data;
    assign muldiv_operands.rs2 = rs2_data;
    assign muldiv_operands.op  = decoded.fn3[1:0];
    assign muldiv_operands.reuse_result = 1'b0;

endmodule

// File: hdl/div_reuse_tracker.sv
// Tracks only the most recent issued divide; any write to its sources invalidates reuse
`include "decode_settings.svh"

module div_reuse_tracker (
    input  logic clk,
    input  logic rst,
    input  decode_pkg::decoded_t decoded,
    input  logic instruction_issued,
    input  decode_pkg::unit_vec_t unit_request,
    output logic reuse_result
);
    import decode_pkg::*;

    logic [`REG_ADDR_W-1:0] prev_rs1_addr;
    logic [`REG_ADDR_W-1:0] prev_rs2_addr;
    logic prev_valid;
    logic is_div;
    logic div_issue;
    logic [`REG_ADDR_W-1:0] watch_rs1;
    logic [`REG_ADDR_W-1:0] watch_rs2;
    logic clear;

    assign is_div    = decoded.needed[DIV_UNIT];
    assign div_issue = unit_request[DIV_UNIT];

    // Source addresses of the last issued divide
    always_ff @(posedge clk) begin
        if (div_issue) begin
            prev_rs1_addr <= decoded.rs1_addr;
            prev_rs2_addr <= decoded.rs2_addr;
        end
    end

    // A divide is checked against its own sources, anything else against the stored ones
    assign watch_rs1 = is_div ? decoded.rs1_addr : prev_rs1_addr;
    assign watch_rs2 = is_div ? decoded.rs2_addr : prev_rs2_addr;
    assign clear = decoded.uses_rd &&
                   ((decoded.rd_addr == watch_rs1) || (decoded.rd_addr == watch_rs2));

    // Clear takes priority over set
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_valid <= 1'b0;
        end else if (instruction_issued && clear) begin
            prev_valid <= 1'b0;
        end else if (div_issue) begin
            prev_valid <= 1'b1;
        end
    end

    assign reuse_result = prev_valid &&
                          (prev_rs1_addr == decoded.rs1_addr) &&
                          (prev_rs2_addr == decoded.rs2_addr);

endmodule

// File: hdl/decode_and_issue.sv
// Single-issue decode stage; everything but unit_request_r and divide reuse is same-cycle
`include "decode_settings.svh"

module decode_and_issue (
    input  logic clk,
    input  logic rst,

    // Fetch side
    input  logic fb_valid,
    input  decode_pkg::fetch_packet_t fb,
    output logic pre_decode_pop,

    // Register file and scoreboard
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic rs1_conflict,
    input  logic rs2_conflict,
    output decode_pkg::regfile_issue_t rf_issue,

    // Unit handshake and control
    input  decode_pkg::unit_vec_t unit_ready,
    input  logic issue_hold,
    input  logic flush,
    output logic instruction_issued,
    output decode_pkg::unit_vec_t unit_request,
    output decode_pkg::unit_vec_t unit_request_r,

    // Operand bundles
    output decode_pkg::alu_inputs_t alu_inputs,
    output decode_pkg::ls_inputs_t ls_inputs,
    output decode_pkg::branch_inputs_t branch_inputs,
    output decode_pkg::muldiv_inputs_t muldiv_inputs
);
    import decode_pkg::*;

    decoded_t decoded;
    muldiv_inputs_t muldiv_operands;
    logic reuse_result;

    //////////////////////////////////////////////////////////////////////
    // Decode and issue

    unit_select unit_select_i (
        .fb      (fb),
        .decoded (decoded)
    );

    issue_control issue_control_i (
        .clk                (clk),
        .rst                (rst),
        .fb_valid           (fb_valid),
        .decoded            (decoded),
        .unit_ready         (unit_ready),
        .rs1_conflict       (rs1_conflict),
        .rs2_conflict       (rs2_conflict),
        .issue_hold         (issue_hold),
        .flush              (flush),
        .instruction_issued (instruction_issued),
        .pre_decode_pop     (pre_decode_pop),
        .unit_request       (unit_request),
        .unit_request_r     (unit_request_r),
        .rf_issue           (rf_issue)
    );

    //////////////////////////////////////////////////////////////////////
    // Operand generation

    alu_operand_gen alu_operand_gen_i (
        .fb         (fb),
        .decoded    (decoded),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_inputs (alu_inputs)
    );

    mem_branch_operand_gen mem_branch_operand_gen_i (
        .fb              (fb),
        .decoded         (decoded),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .rs2_conflict    (rs2_conflict),
        .ls_inputs       (ls_inputs),
        .branch_inputs   (branch_inputs),
        .muldiv_operands (muldiv_operands)
    );

    div_reuse_tracker div_reuse_tracker_i (
        .clk                (clk),
        .rst                (rst),
        .decoded            (decoded),
        .instruction_issued (instruction_issued),
        .unit_request       (unit_request),
        .reuse_result       (reuse_result)
    );

    always_comb begin
        muldiv_inputs = muldiv_operands;
        muldiv_inputs.reuse_result = reuse_result;
    end

endmodule

// File: tb/decode_tests.svh
// Directed test tasks for decode_tb; inputs change on rising edges, outputs are checked on falling

// Major opcodes, full 7-bit form
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

// One bit per unit, ALU at bit 0
localparam unit_vec_t U_ALU    = 5'b00001;
localparam unit_vec_t U_BRANCH = 5'b00010;
localparam unit_vec_t U_LS     = 5'b00100;
localparam unit_vec_t U_MUL    = 5'b01000;
localparam unit_vec_t U_DIV    = 5'b10000;

localparam logic [6:0] MULDIV_FN7 = 7'b0000001;

//////////////////////////////////////////////////////////////////////
// Instruction encoding

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] fn3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, fn3, rd, opc};
endfunction

function automatic logic [31:0] r_type(input logic [6:0] fn7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] fn3,
                                       input logic [4:0] rd, input logic [6:0] opc);
    return {fn7, rs2, rs1, fn3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] fn3);
    return {imm[11:5], rs2, rs1, fn3, imm[4:0], OPC_STORE};
endfunction

// Zero branch and jump offsets throughout
function automatic logic [31:0] b_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [2:0] fn3);
    return {7'b0, rs2, rs1, fn3, 5'b0, OPC_BRANCH};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_type(input logic [4:0] rd);
    return {20'b0, rd, OPC_JAL};
endfunction

// Extra top bit copies the sign unless the operation is unsigned
function automatic logic [32:0] widen(input logic [31:0] v, input logic unsigned_op);
    return {v[31] & ~unsigned_op, v};
endfunction

//////////////////////////////////////////////////////////////////////
// Driving and checking

task automatic apply(input logic [31:0] instr, input logic [31:0] pc,
                     input logic [31:0] d1, input logic [31:0] d2);
    @(posedge clk);
    fb_valid <= 1'b1;
    fb <= {pc, instr};
    rs1_data <= d1;
    rs2_data <= d2;
    @(negedge clk);
endtask

task automatic clear_blocks(input logic keep_valid);
    @(posedge clk);
    fb_valid <= keep_valid;
    unit_ready <= '1;
    issue_hold <= 1'b0;
    flush <= 1'b0;
    rs1_conflict <= 1'b0;
    rs2_conflict <= 1'b0;
    @(negedge clk);
endtask

task automatic expect_issue(input unit_vec_t exp_units, input logic exp_rd_write);
    assert (unit_request == exp_units)
        else report_mismatch($sformatf("unit_request %b, expected %b", unit_request, exp_units));
    assert (instruction_issued && pre_decode_pop)
        else report_mismatch($sformatf("issued %b pop %b, expected both high",
                                       instruction_issued, pre_decode_pop));
    assert (rf_issue.rd_write == exp_rd_write)
        else report_mismatch($sformatf("rd_write %b, expected %b", rf_issue.rd_write,
                                       exp_rd_write));
endtask

task automatic expect_blocked(input string what);
    assert (!instruction_issued && !pre_decode_pop && unit_request == '0)
        else report_mismatch($sformatf("%s did not block issue, request %b", what,
                                       unit_request));
endtask

task automatic expect_registered(input unit_vec_t exp_units);
    assert (unit_request_r == exp_units)
        else report_mismatch($sformatf("unit_request_r %b, expected %b", unit_request_r,
                                       exp_units));
endtask

task automatic issue_case(input logic [31:0] instr, input unit_vec_t exp_units,
                          input logic exp_rd_write);
    apply(instr, 32'h0000_1000, $random(seed), $random(seed));
    expect_issue(exp_units, exp_rd_write);
    clear_blocks(1'b0);
    expect_registered(exp_units);
endtask

task automatic alu_pair(input logic [32:0] exp_in1, input logic [32:0] exp_in2,
                        input string what);
    assert (alu_inputs.in1 == exp_in1 && alu_inputs.in2 == exp_in2)
        else report_mismatch($sformatf("%s in1 %h in2 %h, expected %h %h", what,
                                       alu_inputs.in1, alu_inputs.in2, exp_in1, exp_in2));
endtask

task automatic blocked_case(input unit_vec_t ready, input logic hold, input logic fl,
                            input logic c1, input logic c2, input string what);
    @(posedge clk);
    fb_valid <= 1'b1;
    fb <= {32'h0000_0100, r_type(7'b0, 5'd2, 5'd1, 3'b000, 5'd5, OPC_OP)};
    unit_ready <= ready;
    issue_hold <= hold;
    flush <= fl;
    rs1_conflict <= c1;
    rs2_conflict <= c2;
    @(negedge clk);
    expect_blocked(what);
    // Same instruction still presented, now free to go
    clear_blocks(1'b1);
    expect_registered('0);
    expect_issue(U_ALU, 1'b1);
    clear_blocks(1'b0);
    expect_registered(U_ALU);
endtask

task automatic expect_reuse(input logic exp_reuse, input string what);
    assert (muldiv_inputs.reuse_result == exp_reuse)
        else report_mismatch($sformatf("%s reuse_result %b, expected %b", what,
                                       muldiv_inputs.reuse_result, exp_reuse));
endtask

//////////////////////////////////////////////////////////////////////
// Tests

task automatic unit_selection;
    issue_case(i_type(12'd3, 5'd1, 3'b000, 5'd5, OPC_OP_IMM), U_ALU, 1'b1);
    issue_case(b_type(5'd2, 5'd1, 3'b000), U_BRANCH, 1'b0);
    issue_case(i_type(12'd8, 5'd1, 3'b010, 5'd6, OPC_LOAD), U_LS, 1'b1);
    issue_case(s_type(12'd8, 5'd2, 5'd1, 3'b010), U_LS, 1'b0);
    issue_case(r_type(MULDIV_FN7, 5'd2, 5'd1, 3'b000, 5'd7, OPC_OP), U_MUL, 1'b1);
    issue_case(r_type(MULDIV_FN7, 5'd4, 5'd3, 3'b100, 5'd8, OPC_OP), U_DIV, 1'b1);
    // Link to x0, so no register write
    issue_case(j_type(5'd0), U_ALU | U_BRANCH, 1'b0);
endtask

task automatic alu_operands;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    a = $random(seed);
    b = $random(seed);
    pc = $random(seed) & 32'hFFFF_FFFC;
    apply(u_type(20'hABCDE, 5'd5, OPC_LUI), pc, a, b);
    alu_pair(33'h0, widen(32'hABCD_E000, 1'b0), "LUI");
    apply(u_type(20'h80004, 5'd5, OPC_AUIPC), pc, a, b);
    alu_pair(widen(pc, 1'b0), widen(32'h8000_4000, 1'b0), "AUIPC");
    apply(i_type(12'hFFB, 5'd1, 3'b000, 5'd5, OPC_OP_IMM), pc, a, b);
    alu_pair(widen(a, 1'b0), 33'h1_FFFF_FFFB, "ADDI");
    apply(j_type(5'd1), pc, a, b);
    alu_pair(widen(pc, 1'b0), 33'h0_0000_0004, "JAL");
    apply(r_type(7'b0, 5'd2, 5'd1, 3'b011, 5'd5, OPC_OP), pc, a, b);
    alu_pair(widen(a, 1'b1), widen(b, 1'b1), "SLTU");
    clear_blocks(1'b0);
endtask

task automatic back_pressure;
    blocked_case(~U_ALU, 1'b0, 1'b0, 1'b0, 1'b0, "ALU not ready");
    blocked_case('1, 1'b1, 1'b0, 1'b0, 1'b0, "issue_hold");
    blocked_case('1, 1'b0, 1'b1, 1'b0, 1'b0, "flush");
    blocked_case('1, 1'b0, 1'b0, 1'b1, 1'b0, "rs1_conflict");
    blocked_case('1, 1'b0, 1'b0, 1'b0, 1'b1, "rs2_conflict");
    // Store goes ahead and forwards its data later
    @(posedge clk);
    fb_valid <= 1'b1;
    fb <= {32'h0000_0200, s_type(12'd16, 5'd2, 5'd1, 3'b010)};
    rs2_conflict <= 1'b1;
    @(negedge clk);
    expect_issue(U_LS, 1'b0);
    assert (ls_inputs.forwarded_store)
        else report_mismatch("forwarded_store low on a store with an rs2 conflict");
    clear_blocks(1'b0);
    expect_registered(U_LS);
endtask

task automatic mem_branch_bundles;
    apply(i_type(12'h5A7, 5'd1, 3'b100, 5'd6, OPC_LOAD), 32'h300, 32'h0, 32'h0);
    assert (ls_inputs.offset == 12'h5A7 && {ls_inputs.load, ls_inputs.store} == 2'b10 &&
            ls_inputs.fn3 == 3'b100)
        else report_mismatch($sformatf("load offset %h load %b store %b fn3 %b",
                                       ls_inputs.offset, ls_inputs.load, ls_inputs.store,
                                       ls_inputs.fn3));
    apply(s_type(12'h5A7, 5'd2, 5'd1, 3'b010), 32'h304, 32'h0, 32'h0);
    assert (ls_inputs.offset == 12'h5A7 && {ls_inputs.load, ls_inputs.store} == 2'b01 &&
            ls_inputs.fn3 == 3'b010)
        else report_mismatch($sformatf("store offset %h load %b store %b fn3 %b",
                                       ls_inputs.offset, ls_inputs.load, ls_inputs.store,
                                       ls_inputs.fn3));
    apply(b_type(5'd2, 5'd1, 3'b100), 32'h308, 32'h0, 32'h0);
    assert (branch_inputs.use_signed)
        else report_mismatch("use_signed low for BLT");
    apply(b_type(5'd2, 5'd1, 3'b110), 32'h30C, 32'h0, 32'h0);
    assert (!branch_inputs.use_signed)
        else report_mismatch("use_signed high for BLTU");
    apply(j_type(5'd1), 32'h310, 32'h0, 32'h0);
    assert ({branch_inputs.jal, branch_inputs.jalr} == 2'b10)
        else report_mismatch($sformatf("JAL gives jal %b jalr %b", branch_inputs.jal,
                                       branch_inputs.jalr));
    apply(i_type(12'h0, 5'd2, 3'b000, 5'd1, OPC_JALR), 32'h314, 32'h0, 32'h0);
    assert ({branch_inputs.jal, branch_inputs.jalr} == 2'b01)
        else report_mismatch($sformatf("JALR gives jal %b jalr %b", branch_inputs.jal,
                                       branch_inputs.jalr));
    clear_blocks(1'b0);
endtask

task automatic divide_reuse;
    @(posedge clk);
    rst <= 1'b1;
    // ADDI keeps requesting the ALU through reset
    fb_valid <= 1'b1;
    fb <= {32'h0000_03F0, i_type(12'd1, 5'd1, 3'b000, 5'd5, OPC_OP_IMM)};
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    fb_valid <= 1'b0;
    @(negedge clk);
    expect_registered('0);
    apply(r_type(MULDIV_FN7, 5'd4, 5'd3, 3'b100, 5'd8, OPC_OP), 32'h400, 32'h0, 32'h0);
    expect_reuse(1'b0, "first divide after reset");
    expect_issue(U_DIV, 1'b1);
    clear_blocks(1'b0);
    apply(r_type(MULDIV_FN7, 5'd4, 5'd3, 3'b100, 5'd9, OPC_OP), 32'h404, 32'h0, 32'h0);
    expect_reuse(1'b1, "repeated divide");
    clear_blocks(1'b0);
    // Overwrite x3, the remembered rs1
    apply(i_type(12'd1, 5'd0, 3'b000, 5'd3, OPC_OP_IMM), 32'h408, 32'h0, 32'h0);
    expect_issue(U_ALU, 1'b1);
    clear_blocks(1'b0);
    apply(r_type(MULDIV_FN7, 5'd4, 5'd3, 3'b100, 5'd10, OPC_OP), 32'h40C, 32'h0, 32'h0);
    expect_reuse(1'b0, "divide after its source was written");
    clear_blocks(1'b0);
    // Divide held back by an unready unit leaves the state alone, even writing its own rs1
    @(posedge clk);
    fb_valid <= 1'b1;
    fb <= {32'h0000_0410, r_type(MULDIV_FN7, 5'd6, 5'd5, 3'b100, 5'd5, OPC_OP)};
    unit_ready <= ~U_DIV;
    @(negedge clk);
    expect_blocked("divide unit not ready");
    clear_blocks(1'b0);
    apply(r_type(MULDIV_FN7, 5'd4, 5'd3, 3'b100, 5'd12, OPC_OP), 32'h414, 32'h0, 32'h0);
    expect_reuse(1'b1, "divide after a held divide");
    clear_blocks(1'b0);
endtask

// File: tb/decode_tb.sv
// Directed tests of the decode stage; stops at the first failing check, tests come from a header
`include "decode_settings.svh"

module decode_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import decode_pkg::*;

    // Directed sequence runs well under 100 cycles, leave generous margin
    localparam int MAX_CYCLES = 400;

    logic clk = 1'b0;
    logic rst;

    logic fb_valid;
    fetch_packet_t fb;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic rs1_conflict;
    logic rs2_conflict;
    unit_vec_t unit_ready;
    logic issue_hold;
    logic flush;

    logic pre_decode_pop;
    logic instruction_issued;
    unit_vec_t unit_request;
    unit_vec_t unit_request_r;
    regfile_issue_t rf_issue;
    alu_inputs_t alu_inputs;
    ls_inputs_t ls_inputs;
    branch_inputs_t branch_inputs;
    muldiv_inputs_t muldiv_inputs;

    integer seed = 72;
    int cycle_count = 0;
    int error_count = 0;

    //////////////////////////////////////////////////////////////////////
    // DUT

    decode_and_issue decode_and_issue_i (
        .clk                (clk),
        .rst                (rst),
        .fb_valid           (fb_valid),
        .fb                 (fb),
        .pre_decode_pop     (pre_decode_pop),
        .rs1_data           (rs1_data),
        .rs2_data           (rs2_data),
        .rs1_conflict       (rs1_conflict),
        .rs2_conflict       (rs2_conflict),
        .rf_issue           (rf_issue),
        .unit_ready         (unit_ready),
        .issue_hold         (issue_hold),
        .flush              (flush),
        .instruction_issued (instruction_issued),
        .unit_request       (unit_request),
        .unit_request_r     (unit_request_r),
        .alu_inputs         (alu_inputs),
        .ls_inputs          (ls_inputs),
        .branch_inputs      (branch_inputs),
        .muldiv_inputs      (muldiv_inputs)
    );

    //////////////////////////////////////////////////////////////////////
    // Clock, timeout and error handling

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    `include "decode_tests.svh"

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        rst <= 1'b1;
        fb_valid <= 1'b0;
        fb <= '0;
        rs1_data <= '0;
        rs2_data <= '0;
        rs1_conflict <= 1'b0;
        rs2_conflict <= 1'b0;
        unit_ready <= '1;
        issue_hold <= 1'b0;
        flush <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        unit_selection();
        alu_operands();
        back_pressure();
        mem_branch_bundles();
        divide_reuse();

        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+hdl
+incdir+tb
hdl/decode_pkg.sv
hdl/unit_select.sv
hdl/issue_control.sv
hdl/alu_operand_gen.sv
hdl/mem_branch_operand_gen.sv
hdl/div_reuse_tracker.sv
hdl/decode_and_issue.sv
tb/decode_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module decode_tb \
    -o decode_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/decode_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
